// File: Makefile
TOP = tb_bus_slave

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: compile.f
+incdir+hdl
hdl/bus_slave_pkg.sv
hdl/slave_in_port.sv
hdl/request_fifo.sv
hdl/slave_memory.sv
hdl/bus_slave.sv
testbench/tb_clock_gen.sv
testbench/tb_bus_slave.sv

// File: hdl/bus_slave.sv
`default_nettype none

`include "bus_slave_defines.svh"

module bus_slave
(
	input  wire                        trig_event,
	input  wire                        reset,
	input  wire                        rx_address,
	input  wire                        rx_data,
	input  wire                        master_valid,
	input  wire                        read_en,
	input  wire                        write_en,
	input  wire                        read_ack,
	output logic                       slave_ready,
	output logic                       rx_done,
	output logic                       read_req,
	output logic [`BUS_DATA_WIDTH-1:0] read_data
);

	logic                        fifo_full;
	logic                        push;
	logic                        pop;
	logic                        not_empty;
	bus_slave_pkg::bus_request_t request_in;  // receiver to fifo
	bus_slave_pkg::bus_request_t request_out; // fifo head to controller

	slave_in_port i_in_port
	(
		.trig_event   (trig_event),
		.reset        (reset),
		.rx_address   (rx_address),
		.rx_data      (rx_data),
		.master_valid (master_valid),
		.read_en      (read_en),
		.write_en     (write_en),
		.fifo_full    (fifo_full),
		.slave_ready  (slave_ready),
		.rx_done      (rx_done),
		.push         (push),
		.request_in   (request_in)
	);

	request_fifo #(.DEPTH(`REQ_FIFO_DEPTH)) i_fifo
	(
		.trig_event  (trig_event),
		.reset       (reset),
		.push        (push),
		.request_in  (request_in),
		.pop         (pop),
		.request_out (request_out),
		.full        (fifo_full),
		.not_empty   (not_empty)
	);

	slave_memory i_memory
	(
		.trig_event  (trig_event),
		.reset       (reset),
		.not_empty   (not_empty),
		.request_out (request_out),
		.pop         (pop),
		.read_req    (read_req),
		.read_ack    (read_ack),
		.read_data   (read_data)
	);

endmodule

`default_nettype wire

// File: hdl/bus_slave_defines.svh
`ifndef BUS_SLAVE_DEFINES_SVH
`define BUS_SLAVE_DEFINES_SVH

// serial bus geometry
`define BUS_ADDR_WIDTH 12 // 4096 byte locations
`define BUS_DATA_WIDTH 8

// request buffer between receiver and memory controller
`define REQ_FIFO_DEPTH 4

`endif

// File: hdl/bus_slave_pkg.sv
`default_nettype none

`include "bus_slave_defines.svh"

package bus_slave_pkg;

	// write wins when the master raises both enables
	typedef enum logic
	{
		CMD_WRITE = 1'b0,
		CMD_READ  = 1'b1
	} bus_cmd_t;

	// one finished transfer of 21 bits
	typedef struct packed
	{
		bus_cmd_t                   cmd;
		logic [`BUS_ADDR_WIDTH-1:0] addr;
		logic [`BUS_DATA_WIDTH-1:0] data;
	} bus_request_t;

endpackage

`default_nettype wire

// File: hdl/request_fifo.sv
`default_nettype none

`include "bus_slave_defines.svh"

module request_fifo
#(
	parameter int DEPTH = `REQ_FIFO_DEPTH
)
(
	input  wire                         trig_event,
	input  wire                         reset,
	input  wire                         push,
	input  bus_slave_pkg::bus_request_t request_in,
	input  wire                         pop,
	output bus_slave_pkg::bus_request_t request_out,
	output logic                        full,
	output logic                        not_empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	bus_slave_pkg::bus_request_t mem [DEPTH];
	logic [PTR_W-1:0]            wr_ptr;
	logic [PTR_W-1:0]            rd_ptr;
	logic [CNT_W-1:0]            count;

	assign full        = (count == CNT_W'(DEPTH));
	assign not_empty   = (count != '0);
	assign request_out = mem[rd_ptr]; // head always visible

	always_ff @(posedge trig_event)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// simultaneous push and pop leave the occupancy unchanged
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge trig_event)
	begin
		if (push)
			mem[wr_ptr] <= request_in;
	end

	// the receiver holds off on full, the controller on empty
	assert property (@(posedge trig_event) disable iff (reset) push |-> !full);
	assert property (@(posedge trig_event) disable iff (reset) pop |-> not_empty);

endmodule

`default_nettype wire

// File: hdl/slave_in_port.sv
`default_nettype none

`include "bus_slave_defines.svh"

module slave_in_port
(
	input  wire                        trig_event,
	input  wire                        reset,
	input  wire                        rx_address,
	input  wire                        rx_data,
	input  wire                        master_valid,
	input  wire                        read_en,
	input  wire                        write_en,
	input  wire                        fifo_full,
	output logic                       slave_ready,
	output logic                       rx_done,
	output logic                       push,
	output bus_slave_pkg::bus_request_t request_in
);

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_RECEIVE,
		ST_COMMIT
	} rx_state_t;

	rx_state_t                   state;
	logic [3:0]                  bit_cnt;  // serial bit position
	logic                        has_cmd;  // at least one enable seen at handshake
	bus_slave_pkg::bus_request_t req;
	logic                        handshake;

	// only accept a transfer when the request can be buffered
	assign slave_ready = (state == ST_IDLE) && !fifo_full;
	assign handshake   = master_valid && slave_ready;

	assign rx_done    = (state == ST_COMMIT);
	assign push       = (state == ST_COMMIT) && has_cmd; // no request without an enable
	assign request_in = req;

	always_ff @(posedge trig_event)
	begin
		if (reset)
		begin
			state   <= ST_IDLE;
			bit_cnt <= 4'd0;
			has_cmd <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					bit_cnt <= 4'd0;
					if (handshake)
					begin
						state   <= ST_RECEIVE;
						has_cmd <= write_en || read_en;
					end
				end
				ST_RECEIVE:
				begin
					if (bit_cnt == 4'(`BUS_ADDR_WIDTH - 1))
						state <= ST_COMMIT; // last address bit taken this edge
					else
						bit_cnt <= bit_cnt + 4'd1;
				end
				ST_COMMIT:
				begin
					state   <= ST_IDLE;
					bit_cnt <= 4'd0;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// payload bits land in place lsb first
	always_ff @(posedge trig_event)
	begin
		if (state == ST_IDLE && handshake)
			req.cmd <= write_en ? bus_slave_pkg::CMD_WRITE : bus_slave_pkg::CMD_READ;
		if (state == ST_RECEIVE)
		begin
			req.addr[bit_cnt] <= rx_address;
			if (bit_cnt < 4'(`BUS_DATA_WIDTH))
				req.data[bit_cnt[2:0]] <= rx_data; // data only on the first 8 edges
		end
	end

	// once accepted, the port stays busy until the request is committed
	assert property (@(posedge trig_event) disable iff (reset)
		handshake |=> (!slave_ready) [*12] ##1 (!slave_ready && rx_done));

endmodule

`default_nettype wire

// File: hdl/slave_memory.sv
`default_nettype none

`include "bus_slave_defines.svh"

module slave_memory
(
	input  wire                         trig_event,
	input  wire                         reset,
	input  wire                         not_empty,
	input  bus_slave_pkg::bus_request_t request_out,
	output logic                        pop,
	output logic                        read_req,
	input  wire                         read_ack,
	output logic [`BUS_DATA_WIDTH-1:0]  read_data
);

	localparam int MEM_WORDS = 1 << `BUS_ADDR_WIDTH;

	typedef enum logic [2:0]
	{
		ST_IDLE,
		ST_FETCH,
		ST_EXECUTE,
		ST_REQ_HIGH,
		ST_WAIT_ACK_LOW
	} mem_state_t;

	mem_state_t                  state;
	bus_slave_pkg::bus_request_t cur_req; // request being served
	logic [`BUS_DATA_WIDTH-1:0]  mem [MEM_WORDS];

	assign pop      = (state == ST_IDLE) && not_empty;
	assign read_req = (state == ST_REQ_HIGH);

	always_ff @(posedge trig_event)
	begin
		if (reset)
			state <= ST_IDLE;
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (pop)
						state <= ST_FETCH;
				end
				ST_FETCH:
					state <= ST_EXECUTE;
				ST_EXECUTE:
				begin
					if (cur_req.cmd == bus_slave_pkg::CMD_READ)
						state <= ST_REQ_HIGH;
					else
						state <= ST_IDLE; // write finished
				end
				ST_REQ_HIGH:
				begin
					if (read_ack)
						state <= ST_WAIT_ACK_LOW;
				end
				ST_WAIT_ACK_LOW:
				begin
					if (!read_ack)
						state <= ST_IDLE; // four-phase cycle closed
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// datapath
	always_ff @(posedge trig_event)
	begin
		if (pop)
			cur_req <= request_out;
		if (state == ST_FETCH && cur_req.cmd == bus_slave_pkg::CMD_READ)
			read_data <= mem[cur_req.addr]; // settled one cycle ahead of read_req
		if (state == ST_EXECUTE && cur_req.cmd == bus_slave_pkg::CMD_WRITE)
			mem[cur_req.addr] <= cur_req.data;
	end

	// master may sample read_data any time during the request phase
	assert property (@(posedge trig_event) disable iff (reset)
		read_req |=> !read_req || $stable(read_data));

endmodule

`default_nettype wire

// File: testbench/tb_bus_slave.sv
`default_nettype none

`include "bus_slave_defines.svh"

module tb_bus_slave;

	localparam int CLK_PERIOD    = 40;
	localparam int MAX_ACK_DELAY = 30;
	localparam int NUM_TRANSFERS = 257; // sum over all tests
	// handshake, 12 bits, commit and idle, plus the slowest read return
	localparam int TIMEOUT_CYCLES = NUM_TRANSFERS * (16 + MAX_ACK_DELAY) + 500;

	wire                       trig_event;
	wire                       reset;
	logic                      rx_address;
	logic                      rx_data;
	logic                      master_valid;
	logic                      read_en;
	logic                      write_en;
	logic                      read_ack;
	wire                       slave_ready;
	wire                       rx_done;
	wire                       read_req;
	wire [`BUS_DATA_WIDTH-1:0] read_data;

	integer seed = 32'hfbe2;
	string  cur_test = "none";
	int     errors = 0;
	int     errors_at_start = 0;
	int     tests_passed = 0;
	int     tests_failed = 0;
	int     transfers_sent = 0;
	int     rx_done_count = 0;
	int     reads_issued = 0;
	int     reads_returned = 0;
	int     stall_count = 0;  // transfers that found the fifo full
	int     max_ack_delay = 0;

	logic [`BUS_DATA_WIDTH-1:0] model [logic [`BUS_ADDR_WIDTH-1:0]];
	logic [`BUS_DATA_WIDTH-1:0] expected_reads [$]; // in command order
	logic [`BUS_ADDR_WIDTH-1:0] addr_set [8];

	tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) i_clock
	(
		.trig_event (trig_event),
		.reset      (reset)
	);

	bus_slave i_dut
	(
		.trig_event   (trig_event),
		.reset        (reset),
		.rx_address   (rx_address),
		.rx_data      (rx_data),
		.master_valid (master_valid),
		.read_en      (read_en),
		.write_en     (write_en),
		.read_ack     (read_ack),
		.slave_ready  (slave_ready),
		.rx_done      (rx_done),
		.read_req     (read_req),
		.read_data    (read_data)
	);

	always @(negedge trig_event)
	begin
		if (rx_done)
			rx_done_count++;
	end

	// master side of the read return with a random ack delay
	initial
	begin : read_responder
		int                         delay;
		logic [`BUS_DATA_WIDTH-1:0] exp;
		read_ack = 1'b0;
		forever
		begin
			@(negedge trig_event);
			if (read_req)
			begin
				reads_returned++;
				if (expected_reads.size() == 0)
				begin
					errors++;
					$display("error in %s: read_req rose with no read outstanding", cur_test);
				end
				else
				begin
					exp = expected_reads.pop_front();
					if (read_data !== exp)
					begin
						errors++;
						$display("mismatch %s: expected %h, actual %h", cur_test, exp, read_data);
					end
				end
				delay = int'($unsigned($random(seed)) % (max_ack_delay + 1));
				repeat (delay) @(negedge trig_event);
				read_ack = 1'b1;
				while (read_req)
					@(negedge trig_event);
				read_ack = 1'b0; // closes the four-phase cycle
			end
		end
	end

	task automatic send_transfer(input logic we, input logic re,
		input logic [`BUS_ADDR_WIDTH-1:0] a, input logic [`BUS_DATA_WIDTH-1:0] d);
		@(negedge trig_event);
		if (!slave_ready)
			stall_count++;
		while (!slave_ready)
			@(negedge trig_event);
		master_valid = 1'b1;
		write_en     = we;
		read_en      = re;
		@(negedge trig_event); // handshake edge done
		master_valid = 1'b0;
		write_en     = 1'b0;
		read_en      = 1'b0;
		for (int k = 0; k < `BUS_ADDR_WIDTH; k++)
		begin
			rx_address = a[k];
			rx_data    = (k < `BUS_DATA_WIDTH) ? d[k] : 1'b0;
			@(negedge trig_event);
		end
		transfers_sent++;
		// write wins and no enable means no request
		if (we)
			model[a] = d;
		else if (re)
		begin
			expected_reads.push_back(model[a]);
			reads_issued++;
		end
	endtask

	task automatic random_transfer(input int read_pct);
		logic [`BUS_ADDR_WIDTH-1:0] a;
		logic [`BUS_DATA_WIDTH-1:0] d;
		a = addr_set[$unsigned($random(seed)) % 8];
		d = `BUS_DATA_WIDTH'($random(seed));
		if (model.exists(a) && ($unsigned($random(seed)) % 100) < read_pct)
			send_transfer(1'b0, 1'b1, a, d);
		else
			send_transfer(1'b1, 1'b0, a, d);
	endtask

	task automatic wait_idle();
		@(negedge trig_event);
		while (expected_reads.size() != 0 || read_req || read_ack || !slave_ready)
			@(negedge trig_event);
	endtask

	task automatic start_test(input string name, input int ack_delay);
		cur_test        = name;
		errors_at_start = errors;
		max_ack_delay   = ack_delay;
	endtask

	task automatic end_test();
		wait_idle();
		if (rx_done_count != transfers_sent)
		begin
			errors++;
			$display("error in %s: %0d rx_done pulses for %0d transfers", cur_test,
				rx_done_count, transfers_sent);
		end
		if (reads_returned != reads_issued)
		begin
			errors++;
			$display("error in %s: %0d reads returned for %0d issued", cur_test,
				reads_returned, reads_issued);
		end
		if (errors == errors_at_start)
		begin
			tests_passed++;
			$display("test %s: passed", cur_test);
		end
		else
		begin
			tests_failed++;
			$display("test %s: failed", cur_test);
		end
	endtask

	initial
	begin : main
		logic [`BUS_ADDR_WIDTH-1:0] a;
		logic [`BUS_DATA_WIDTH-1:0] d;
		int                         stalls_before;
		rx_address   = 1'b0;
		rx_data      = 1'b0;
		master_valid = 1'b0;
		read_en      = 1'b0;
		write_en     = 1'b0;
		for (int i = 0; i < 8; i++)
			addr_set[i] = `BUS_ADDR_WIDTH'($random(seed));
		@(negedge trig_event);
		while (reset)
			@(posedge trig_event); // reset only moves on a falling edge
		@(negedge trig_event);

		start_test("reset_state", 0);
		if (slave_ready !== 1'b1 || read_req !== 1'b0 || rx_done !== 1'b0)
		begin
			errors++;
			$display("error in %s: outputs not idle after reset", cur_test);
		end
		end_test();

		start_test("write_then_read", 0);
		d = `BUS_DATA_WIDTH'($random(seed));
		send_transfer(1'b1, 1'b0, addr_set[0], d);
		send_transfer(1'b0, 1'b1, addr_set[0], 8'h00);
		end_test();

		start_test("random_mix", 3);
		repeat (200)
			random_transfer(50);
		end_test();

		start_test("slow_ack", MAX_ACK_DELAY);
		stalls_before = stall_count;
		repeat (50)
			random_transfer(90); // mostly reads, so the fifo backs up
		if (stall_count == stalls_before)
		begin
			errors++;
			$display("error in %s: slave_ready never fell while the FIFO was full",
				cur_test);
		end
		end_test();

		start_test("no_enable", 2);
		a = addr_set[1];
		d = `BUS_DATA_WIDTH'($random(seed));
		send_transfer(1'b1, 1'b0, a, d);
		send_transfer(1'b0, 1'b0, a, ~d); // must leave the array alone
		wait_idle();
		repeat (8) @(negedge trig_event); // responder flags any stray read_req
		send_transfer(1'b0, 1'b1, a, 8'h00);
		end_test();

		start_test("both_enables", 2);
		a = addr_set[2];
		d = `BUS_DATA_WIDTH'($random(seed));
		send_transfer(1'b1, 1'b1, a, d);
		send_transfer(1'b0, 1'b1, a, 8'h00);
		end_test();

		$display("summary: %0d tests passed, %0d tests failed, %0d errors",
			tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin : watchdog
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("error: run timed out in test %s", cur_test);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen
#(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 5
)
(
	output logic trig_event,
	output logic reset
);

	initial
	begin
		trig_event = 1'b0;
		forever #(PERIOD / 2) trig_event = ~trig_event;
	end

	// release on a falling edge, clear of the sampling edge
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge trig_event);
		@(negedge trig_event);
		reset = 1'b0;
	end

endmodule

`default_nettype wire
